/* Makefile */
TOOL     := verilator
TOP      := eth_rx_tb
FILELIST := list.f
BUILD    := obj_dir
FLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD)
LOG      := sim.log
FAIL_MSG := sim failed
PASS_MSG := sim passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) -f $(FILELIST)

run: compile
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD) $(LOG)

/* common/eth_pkg.sv */
package eth_pkg;

    // XGMII control characters
    parameter logic [7:0] XGMII_START = 8'hFB;
    parameter logic [7:0] XGMII_TERM  = 8'hFD;
    parameter logic [7:0] XGMII_IDLE  = 8'h07;

    // Preamble and start of frame delimiter bytes
    parameter logic [7:0] PREAMBLE_BYTE = 8'h55;
    parameter logic [7:0] SFD_BYTE      = 8'hD5;

    // Ethernet CRC-32, LSB-first form
    parameter logic [31:0] CRC_POLY_REFLECTED = 32'hEDB88320;
    parameter logic [31:0] CRC_INIT           = 32'hFFFFFFFF;

    // One 32-bit XGMII transfer, lane 0 in the low byte
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  ctrl;
    } xgmii_word_t;

    // One output stream beat
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  keep;
        logic        last;
        // High on the last beat when the FCS matched
        logic        user;
    } axis_beat_t;

endpackage

/* design/crc32_slice.sv */
module crc32_slice (
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_clear,
    input  logic [31:0] i_data,
    input  logic [3:0]  i_byte_en,
    output logic [31:0] o_crc
);

    logic [31:0] crc_state;
    logic [31:0] crc_step;

    // One byte through the reflected polynomial, bit 0 first
    function automatic logic [31:0] crc_byte(
        input logic [31:0] crc_in,
        input logic [7:0]  data_byte
    );
        logic [31:0] crc;
        crc = crc_in ^ {24'd0, data_byte};
        for (int b = 0; b < 8; b++) begin
            if (crc[0]) begin
                crc = (crc >> 1) ^ eth_pkg::CRC_POLY_REFLECTED;
            end else begin
                crc = crc >> 1;
            end
        end
        return crc;
    endfunction

    // Lane 0 goes in first, disabled lanes are skipped
    always_comb begin
        crc_step = crc_state;
        for (int i = 0; i < 4; i++) begin
            if (i_byte_en[i]) begin
                crc_step = crc_byte(crc_step, i_data[8*i +: 8]);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset || i_clear) begin
            crc_state <= eth_pkg::CRC_INIT;
        end else begin
            crc_state <= crc_step;
        end
    end

    // Includes this cycle's bytes so the MAC can compare on the terminate word
    assign o_crc = ~crc_step;

endmodule

/* design/eth_rx_top.sv */
module eth_rx_top #(
    parameter int COUNT_WIDTH = 16
) (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  eth_pkg::xgmii_word_t   i_rx_word,
    input  logic                   i_rx_valid,
    output eth_pkg::axis_beat_t    o_rx_beat,
    output logic                   o_rx_valid,
    output logic [COUNT_WIDTH-1:0] o_good_frames,
    output logic [COUNT_WIDTH-1:0] o_bad_frames
);

    logic        crc_clear;
    logic [31:0] crc_data;
    logic [3:0]  crc_byte_en;
    logic [31:0] crc_value;

    rx_mac u_rx_mac (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_rx_word     (i_rx_word),
        .i_rx_valid    (i_rx_valid),
        .i_crc_value   (crc_value),
        .o_crc_clear   (crc_clear),
        .o_crc_data    (crc_data),
        .o_crc_byte_en (crc_byte_en),
        .o_rx_beat     (o_rx_beat),
        .o_rx_valid    (o_rx_valid)
    );

    crc32_slice u_crc32_slice (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_clear   (crc_clear),
        .i_data    (crc_data),
        .i_byte_en (crc_byte_en),
        .o_crc     (crc_value)
    );

    rx_frame_stats #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) u_rx_frame_stats (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_beat        (o_rx_beat),
        .i_beat_valid  (o_rx_valid),
        .o_good_frames (o_good_frames),
        .o_bad_frames  (o_bad_frames)
    );

endmodule

/* dv/clk_gen.sv */
module clk_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic o_clk,
    output logic o_reset
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_reset <= 1'b0;
    end

endmodule

/* dv/eth_rx_sva.sv */
module eth_rx_sva (
    input logic                 i_clk,
    input logic                 i_reset,
    input eth_pkg::xgmii_word_t i_rx_word,
    input logic                 i_rx_valid,
    input eth_pkg::axis_beat_t  i_beat,
    input logic                 i_beat_valid
);

    logic start_seen;
    logic wait_start;

    assign start_seen = i_rx_valid && i_rx_word.ctrl[0]
                        && (i_rx_word.data[7:0] == eth_pkg::XGMII_START);

    // High between frames, until the next start word is taken
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wait_start <= 1'b1;
        end else if (i_beat_valid && i_beat.last) begin
            wait_start <= 1'b1;
        end else if (start_seen) begin
            wait_start <= 1'b0;
        end
    end

    a_quiet_after_reset: assert property (@(posedge i_clk) i_reset |=> !i_beat_valid)
        else $error("Beat valid in the cycle after reset");

    a_last_needs_valid: assert property (
        @(posedge i_clk) disable iff (i_reset) i_beat.last |-> i_beat_valid)
        else $error("Last set on a beat that is not valid");

    a_no_beat_between_frames: assert property (
        @(posedge i_clk) disable iff (i_reset) wait_start |-> !i_beat_valid)
        else $error("Valid beat after a last beat without a new start word");

endmodule

bind eth_rx_top eth_rx_sva u_eth_rx_sva (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_rx_word    (i_rx_word),
    .i_rx_valid   (i_rx_valid),
    .i_beat       (o_rx_beat),
    .i_beat_valid (o_rx_valid)
);

/* dv/eth_rx_tb.sv */
module eth_rx_tb;

    localparam int COUNT_WIDTH = 16;
    localparam int MAX_LEN     = 64;
    localparam int MAX_GAP     = 2;
    localparam int FRAME_COUNT = 53;
    // Start, preamble, data words, terminate and a few idles
    localparam int FRAME_WORDS = 2 + (MAX_LEN + 4) / 4 + 1 + 3;
    localparam int CYCLE_LIMIT = FRAME_COUNT * FRAME_WORDS * (1 + MAX_GAP) + 64 + 200;

    logic                   clk;
    logic                   reset;
    eth_pkg::xgmii_word_t   rx_word;
    logic                   rx_valid;
    eth_pkg::axis_beat_t    rx_beat;
    logic                   beat_valid;
    logic [COUNT_WIDTH-1:0] good_frames;
    logic [COUNT_WIDTH-1:0] bad_frames;

    eth_pkg::axis_beat_t    exp_q[$];
    logic [7:0]             frame_bytes[$];
    logic [COUNT_WIDTH-1:0] exp_good;
    logic [COUNT_WIDTH-1:0] exp_bad;

    clk_gen #(
        .PERIOD       (8),
        .RESET_CYCLES (4)
    ) u_clk_gen (
        .o_clk   (clk),
        .o_reset (reset)
    );

    eth_rx_top #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) u_eth_rx_top (
        .i_clk         (clk),
        .i_reset       (reset),
        .i_rx_word     (rx_word),
        .i_rx_valid    (rx_valid),
        .o_rx_beat     (rx_beat),
        .o_rx_valid    (beat_valid),
        .o_good_frames (good_frames),
        .o_bad_frames  (bad_frames)
    );

    task automatic stop_run();
        $display("sim failed");
        $fatal(1, "Stopped on first error");
    endtask

    task automatic check_beat(input eth_pkg::axis_beat_t got, input eth_pkg::axis_beat_t exp);
        if (got !== exp) begin
            $display("Fail o_rx_beat: got data=%h keep=%h last=%h user=%h", got.data,
                     got.keep, got.last, got.user);
            $display("     expected data=%h keep=%h last=%h user=%h", exp.data,
                     exp.keep, exp.last, exp.user);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input logic [COUNT_WIDTH-1:0] got,
                               input logic [COUNT_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    // Ethernet FCS over the first len bytes, bit serial, LSB first
    function automatic logic [31:0] fcs_of(input int len);
        logic [31:0] crc;
        logic        feedback;
        crc = eth_pkg::CRC_INIT;
        for (int n = 0; n < len; n++) begin
            for (int j = 0; j < 8; j++) begin
                feedback = crc[0] ^ frame_bytes[n][j];
                crc = {1'b0, crc[31:1]};
                if (feedback) begin
                    crc = crc ^ eth_pkg::CRC_POLY_REFLECTED;
                end
            end
        end
        return ~crc;
    endfunction

    function automatic eth_pkg::xgmii_word_t make_word(input logic [31:0] data,
                                                      input logic [3:0] ctrl);
        eth_pkg::xgmii_word_t word;
        word.data = data;
        word.ctrl = ctrl;
        return word;
    endfunction

    function automatic eth_pkg::xgmii_word_t idle_word();
        return make_word({4{eth_pkg::XGMII_IDLE}}, 4'hF);
    endfunction

    function automatic logic [31:0] bytes_word(input int w);
        return {frame_bytes[4*w+3], frame_bytes[4*w+2], frame_bytes[4*w+1], frame_bytes[4*w]};
    endfunction

    task automatic check_reference();
        string text;
        text = "123456789";
        frame_bytes.delete();
        for (int n = 0; n < text.len(); n++) begin
            frame_bytes.push_back(text[n]);
        end
        if (fcs_of(9) !== 32'hCBF43926) begin
            $display("Reference CRC model is wrong for the standard check string");
            stop_run();
        end
    endtask

    // Optional random low-valid cycles before each word
    task automatic send_word(input eth_pkg::xgmii_word_t word, input bit gaps_on);
        eth_pkg::xgmii_word_t junk;
        int                   gap;
        gap = gaps_on ? $urandom_range(0, MAX_GAP) : 0;
        repeat (gap) begin
            junk.data = $urandom;
            junk.ctrl = 4'($urandom);
            @(posedge clk);
            rx_word  <= junk;
            rx_valid <= 1'b0;
        end
        @(posedge clk);
        rx_word  <= word;
        rx_valid <= 1'b1;
    endtask

    task automatic send_idles(input int count, input bit gaps_on);
        repeat (count) send_word(idle_word(), gaps_on);
    endtask

    task automatic send_frame(input int len, input int flip_at, input bit gaps_on);
        eth_pkg::axis_beat_t  beat;
        eth_pkg::xgmii_word_t word;
        logic [31:0]          fcs;
        int                   full;
        int                   lane;
        bit                   good;
        frame_bytes.delete();
        for (int n = 0; n < len; n++) begin
            frame_bytes.push_back(8'($urandom_range(0, 255)));
        end
        fcs = fcs_of(len);
        for (int k = 0; k < 4; k++) begin
            frame_bytes.push_back(fcs[8*k +: 8]);
        end
        if (flip_at >= 0) begin
            frame_bytes[flip_at] = frame_bytes[flip_at] ^ 8'($urandom_range(1, 255));
        end
        good = fcs_of(len) == {frame_bytes[len+3], frame_bytes[len+2],
                               frame_bytes[len+1], frame_bytes[len]};
        full = (len + 4) / 4;
        lane = (len + 4) % 4;

        // Full words first, then the terminate beat
        for (int w = 0; w < full; w++) begin
            beat      = '0;
            beat.data = bytes_word(w);
            beat.keep = 4'b1111;
            exp_q.push_back(beat);
        end
        beat = '0;
        word = idle_word();
        for (int i = 0; i < lane; i++) begin
            beat.data[8*i +: 8] = frame_bytes[4*full + i];
            beat.keep[i]        = 1'b1;
            word.data[8*i +: 8] = frame_bytes[4*full + i];
            word.ctrl[i]        = 1'b0;
        end
        word.data[8*lane +: 8] = eth_pkg::XGMII_TERM;
        beat.last = 1'b1;
        beat.user = good;
        exp_q.push_back(beat);
        if (good) begin
            exp_good = exp_good + 1'b1;
        end else begin
            exp_bad = exp_bad + 1'b1;
        end

        send_word(make_word({{3{eth_pkg::PREAMBLE_BYTE}}, eth_pkg::XGMII_START}, 4'b0001),
                  gaps_on);
        send_word(make_word({eth_pkg::SFD_BYTE, {3{eth_pkg::PREAMBLE_BYTE}}}, 4'b0000),
                  gaps_on);
        for (int w = 0; w < full; w++) begin
            send_word(make_word(bytes_word(w), 4'b0000), gaps_on);
        end
        send_word(word, gaps_on);
    endtask

    // Start characters off lane 0 and an unframed body must stay silent
    task automatic send_junk();
        eth_pkg::xgmii_word_t word;
        for (int l = 1; l < 4; l++) begin
            word = idle_word();
            word.data[8*l +: 8] = eth_pkg::XGMII_START;
            send_word(word, 1'b0);
        end
        send_word(make_word({eth_pkg::SFD_BYTE, {3{eth_pkg::PREAMBLE_BYTE}}}, 4'b0000), 1'b0);
        repeat (3) send_word(make_word($urandom, 4'b0000), 1'b0);
        word = idle_word();
        word.data[7:0] = eth_pkg::XGMII_TERM;
        send_word(word, 1'b0);
    endtask

    task automatic finish_test();
        send_idles(2, 1'b0);
        while (exp_q.size() != 0) begin
            send_idles(1, 1'b0);
        end
        send_idles(2, 1'b0);
        @(negedge clk);
        check_count("o_good_frames", good_frames, exp_good);
        check_count("o_bad_frames", bad_frames, exp_bad);
    endtask

    initial begin : stimulus
        int len;
        int flip;
        rx_word  = make_word({{3{eth_pkg::PREAMBLE_BYTE}}, eth_pkg::XGMII_START}, 4'b0001);
        rx_valid = 1'b1;
        exp_good = '0;
        exp_bad  = '0;
        void'($urandom(70));
        check_reference();
        @(posedge clk);
        // Start then body words under reset, no frame may survive it
        rx_word <= make_word($urandom, 4'b0000);
        while (reset) @(posedge clk);
        finish_test();

        send_frame(16, -1, 1'b0);
        finish_test();

        // Terminate in lanes 1, 2, 3 and 0
        for (int l = 17; l <= 20; l++) begin
            send_frame(l, -1, 1'b0);
            send_idles(2, 1'b0);
        end
        finish_test();

        send_frame(24, 24 + int'($urandom_range(0, 3)), 1'b0);
        finish_test();

        repeat (6) begin
            send_frame(int'($urandom_range(1, MAX_LEN)), -1, 1'b1);
            send_idles(3, 1'b1);
        end
        finish_test();

        send_junk();
        send_frame(20, -1, 1'b0);
        finish_test();

        repeat (40) begin
            len  = $urandom_range(1, MAX_LEN);
            flip = -1;
            if ($urandom_range(0, 2) == 0) begin
                flip = $urandom_range(0, len + 3);
            end
            send_frame(len, flip, 1'($urandom_range(0, 1)));
            send_idles(int'($urandom_range(1, 3)), 1'b1);
        end
        finish_test();

        $display("sim passed");
        $finish;
    end

    // Outputs are settled by the falling edge
    initial begin : compare
        eth_pkg::axis_beat_t exp_beat;
        forever begin
            @(negedge clk);
            if (!reset && beat_valid) begin
                if (exp_q.size() == 0) begin
                    $display("A beat came out while no beat was expected");
                    stop_run();
                end else begin
                    exp_beat = exp_q.pop_front();
                    check_beat(rx_beat, exp_beat);
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > CYCLE_LIMIT) begin
                $display("Timeout after %0d cycles, the run did not finish", CYCLE_LIMIT);
                stop_run();
            end
        end
    end

endmodule

/* list.f */
common/eth_pkg.sv
design/crc32_slice.sv
rx_mac/rx_mac.sv
rx_mac/rx_frame_stats.sv
design/eth_rx_top.sv
dv/clk_gen.sv
dv/eth_rx_sva.sv
dv/eth_rx_tb.sv

/* rx_mac/rx_frame_stats.sv */
module rx_frame_stats #(
    parameter int COUNT_WIDTH = 16
) (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  eth_pkg::axis_beat_t    i_beat,
    input  logic                   i_beat_valid,
    output logic [COUNT_WIDTH-1:0] o_good_frames,
    output logic [COUNT_WIDTH-1:0] o_bad_frames
);

    logic frame_end;
    logic good_full;
    logic bad_full;

    assign frame_end = i_beat_valid && i_beat.last;

    // Counters stick at all ones
    assign good_full = &o_good_frames;
    assign bad_full  = &o_bad_frames;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_good_frames <= '0;
            o_bad_frames  <= '0;
        end else if (frame_end) begin
            if (i_beat.user) begin
                if (!good_full) begin
                    o_good_frames <= o_good_frames + 1'b1;
                end
            end else begin
                if (!bad_full) begin
                    o_bad_frames <= o_bad_frames + 1'b1;
                end
            end
        end
    end

endmodule

/* rx_mac/rx_mac.sv */
module rx_mac (
    input  logic                i_clk,
    input  logic                i_reset,

    // XGMII receive side
    input  eth_pkg::xgmii_word_t i_rx_word,
    input  logic                i_rx_valid,

    // CRC engine
    input  logic [31:0]         i_crc_value,
    output logic                o_crc_clear,
    output logic [31:0]         o_crc_data,
    output logic [3:0]          o_crc_byte_en,

    // Output stream
    output eth_pkg::axis_beat_t o_rx_beat,
    output logic                o_rx_valid
);

    typedef enum logic {
        ST_IDLE,
        ST_DATA
    } rx_state_t;

    rx_state_t state;
    rx_state_t state_next;

    logic        preamble_next;
    logic [31:0] prev_data;
    logic [3:0]  prev_en;

    logic        start_found;
    logic [3:0]  term_loc;
    logic        term_found;
    logic [1:0]  term_lane;
    logic [3:0]  term_keep;
    logic        beat_en;
    logic [63:0] fcs_window;
    logic [31:0] fcs_captured;

    // Start only counts in lane 0
    assign start_found = i_rx_valid && (state == ST_IDLE) && i_rx_word.ctrl[0]
                         && (i_rx_word.data[7:0] == eth_pkg::XGMII_START);

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            term_loc[i] = i_rx_word.ctrl[i]
                          && (i_rx_word.data[8*i +: 8] == eth_pkg::XGMII_TERM);
        end
    end

    // Word after the start carries the SFD and is dropped
    assign beat_en    = i_rx_valid && (state == ST_DATA) && !preamble_next;
    assign term_found = beat_en && (|term_loc);

    // Lowest terminate lane wins, keep covers the lanes below it
    always_comb begin
        term_lane = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (term_loc[i]) begin
                term_lane = 2'(i);
            end
        end
        for (int i = 0; i < 4; i++) begin
            term_keep[i] = (i < int'(term_lane));
        end
    end

    // FCS straddles the held word and the terminate word
    assign fcs_window   = {i_rx_word.data, prev_data};
    assign fcs_captured = fcs_window[8*term_lane +: 32];

    always_comb begin
        o_rx_beat = '0;
        if (beat_en) begin
            o_rx_beat.keep = term_found ? term_keep : 4'b1111;
            o_rx_beat.last = term_found;
            o_rx_beat.user = term_found && (fcs_captured == i_crc_value);
            for (int i = 0; i < 4; i++) begin
                if (o_rx_beat.keep[i]) begin
                    o_rx_beat.data[8*i +: 8] = i_rx_word.data[8*i +: 8];
                end
            end
        end
    end

    assign o_rx_valid = beat_en;

    // CRC runs one accepted word behind, so FCS bytes can be cut out in time
    assign o_crc_clear = (state == ST_IDLE);
    assign o_crc_data  = prev_data;

    always_comb begin
        if (!i_rx_valid) begin
            o_crc_byte_en = 4'b0000;
        end else if (term_found) begin
            o_crc_byte_en = term_keep & prev_en;
        end else begin
            o_crc_byte_en = prev_en;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (start_found) begin
                    state_next = ST_DATA;
                end
            end
            ST_DATA: begin
                if (term_found) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state         <= ST_IDLE;
            preamble_next <= 1'b0;
            prev_en       <= 4'b0000;
        end else if (i_rx_valid) begin
            state         <= state_next;
            preamble_next <= start_found;
            // Only bytes that left as a beat may enter the CRC later
            prev_en       <= o_rx_beat.keep;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rx_valid) begin
            prev_data <= i_rx_word.data;
        end
    end

endmodule
